// File: design/shift_pkg.sv
// Shift datapath constants
package shift_pkg;

    // -------------------------------------------------------------------------
    // datapath
    // -------------------------------------------------------------------------
    localparam int DATA_W  = 32;                 // operand and result width.
    localparam int AMT_W   = 5;                  // binary shift amount width.
    localparam int TILE_W  = 8;                  // one tile covers one byte.
    localparam int N_TILES = DATA_W / TILE_W;    // byte lanes per direction.

    // -------------------------------------------------------------------------
    // command queue and status
    // -------------------------------------------------------------------------
    localparam int CMD_W      = DATA_W + AMT_W;  // operand above, amount below.
    localparam int FIFO_DEPTH = 4;               // must stay a power of two.
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = 8;               // completion count wraps at 256.

endpackage

// File: design/axil_pkg.sv
// AXI4-Lite register map
package axil_pkg;

    localparam int ADDR_W = 5;                   // covers offsets 0x00 to 0x1C.
    localparam int RESP_W = 2;

    // -------------------------------------------------------------------------
    // register offsets
    // -------------------------------------------------------------------------
    localparam logic [ADDR_W-1:0] REG_OPERAND   = 5'h00;  // read/write.
    localparam logic [ADDR_W-1:0] REG_AMOUNT    = 5'h04;  // a write queues a command.
    localparam logic [ADDR_W-1:0] REG_RES_LEFT  = 5'h08;  // read only.
    localparam logic [ADDR_W-1:0] REG_RES_RIGHT = 5'h0C;  // read only.
    localparam logic [ADDR_W-1:0] REG_STATUS    = 5'h10;  // count and idle flag.

    // -------------------------------------------------------------------------
    // response codes
    // -------------------------------------------------------------------------
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

// File: design/shift_tile_8.sv
// Byte shift tile
`timescale 1ns/1ps

module shift_tile_8 (
    input  logic [shift_pkg::TILE_W-1:0]  shift,
    input  logic [shift_pkg::TILE_W-2:0]  sel,
    input  logic [shift_pkg::TILE_W-1:0]  din,
    output logic [shift_pkg::TILE_W-1:0]  dleft,
    output logic [shift_pkg::TILE_W-1:0]  dright
);
    import shift_pkg::*;

    // shift[s] selects s within this tile's byte range, sel[s-1] selects s in the
    // range just below, whose overflow bits land here.
    always_comb begin
        dleft  = '0;
        dright = '0;
        for (int o = 0; o < TILE_W; o++) begin
            for (int s = 0; s < TILE_W; s++) begin
                if (s <= o) begin
                    dleft[o] = dleft[o] | (shift[s] & din[o-s]);
                end else begin
                    dleft[o] = dleft[o] | (sel[s-1] & din[o-s+TILE_W]);  // carry in.
                end
                if (o + s < TILE_W) begin
                    dright[o] = dright[o] | (shift[s] & din[o+s]);
                end else begin
                    dright[o] = dright[o] | (sel[s-1] & din[o+s-TILE_W]);
                end
            end
        end
    end

endmodule

// File: design/onehot_shifter_32.sv
// One-hot 32-bit barrel shifter
`timescale 1ns/1ps

module onehot_shifter_32 (
    input  logic [shift_pkg::DATA_W-1:0]  shift,
    input  logic [shift_pkg::DATA_W-1:0]  din,
    output logic [shift_pkg::DATA_W-1:0]  dleftout,
    output logic [shift_pkg::DATA_W-1:0]  drightout
);
    import shift_pkg::*;

    // lane_x[m] holds what the tiles of shift range m put on each output byte.
    wire [N_TILES-1:0][DATA_W-1:0]   lane_l;
    wire [N_TILES-1:0][DATA_W-1:0]   lane_r;
    wire [N_TILES-1:0][TILE_W-2:0]   sel_rng;

    assign sel_rng[0] = '0;  // range 0 has no lower neighbour.

    for (genvar m = 1; m < N_TILES; m++) begin : g_sel
        assign sel_rng[m] = shift[(m-1)*TILE_W+1 +: TILE_W-1];
    end

    // -------------------------------------------------------------------------
    // the tile for source byte j and range m feeds byte j+m left and j-m right
    // -------------------------------------------------------------------------
    for (genvar m = 0; m < N_TILES; m++) begin : g_range
        for (genvar j = 0; j < N_TILES; j++) begin : g_byte
            if (j + m < N_TILES && j >= m) begin : g_both
                shift_tile_8 u_tile (
                    .shift  (shift[m*TILE_W +: TILE_W]),
                    .sel    (sel_rng[m]),
                    .din    (din[j*TILE_W +: TILE_W]),
                    .dleft  (lane_l[m][(j+m)*TILE_W +: TILE_W]),
                    .dright (lane_r[m][(j-m)*TILE_W +: TILE_W])
                );
            end else if (j + m < N_TILES) begin : g_left
                shift_tile_8 u_tile (
                    .shift  (shift[m*TILE_W +: TILE_W]),
                    .sel    (sel_rng[m]),
                    .din    (din[j*TILE_W +: TILE_W]),
                    .dleft  (lane_l[m][(j+m)*TILE_W +: TILE_W]),
                    .dright ()
                );
            end else if (j >= m) begin : g_right
                shift_tile_8 u_tile (
                    .shift  (shift[m*TILE_W +: TILE_W]),
                    .sel    (sel_rng[m]),
                    .din    (din[j*TILE_W +: TILE_W]),
                    .dleft  (),
                    .dright (lane_r[m][(j-m)*TILE_W +: TILE_W])
                );
            end
            // byte j has no source byte for this range in one direction.
            if (j < m) begin : g_lzero
                assign lane_l[m][j*TILE_W +: TILE_W] = '0;
            end
            if (j + m >= N_TILES) begin : g_rzero
                assign lane_r[m][j*TILE_W +: TILE_W] = '0;
            end
        end
    end

    // -------------------------------------------------------------------------
    // OR merge of the byte lanes
    // -------------------------------------------------------------------------
    always_comb begin
        dleftout  = '0;
        drightout = '0;
        for (int m = 0; m < N_TILES; m++) begin
            dleftout  = dleftout | lane_l[m];
            drightout = drightout | lane_r[m];
        end
    end

endmodule

// File: design/shift_cmd_regs.sv
// Shift command register front end
`timescale 1ns/1ps

module shift_cmd_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [axil_pkg::ADDR_W-1:0]   awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [shift_pkg::DATA_W-1:0]  wdata,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [axil_pkg::RESP_W-1:0]   bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [axil_pkg::ADDR_W-1:0]   araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [shift_pkg::DATA_W-1:0]  rdata,
    output logic [axil_pkg::RESP_W-1:0]   rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output logic                          push,
    output logic [shift_pkg::CMD_W-1:0]   push_data,
    input  logic                          full,
    input  logic [shift_pkg::DATA_W-1:0]  res_left,
    input  logic [shift_pkg::DATA_W-1:0]  res_right,
    input  logic [shift_pkg::CNT_W-1:0]   done_count,
    input  logic                          idle
);
    import shift_pkg::*;
    import axil_pkg::*;

    logic [DATA_W-1:0] operand_q;
    logic [AMT_W-1:0]  amount_q;
    logic              wr_fire;
    logic              rd_fire;
    logic              amt_ok;
    logic [RESP_W-1:0] wr_resp;
    logic [RESP_W-1:0] rd_resp;
    logic [DATA_W-1:0] rd_word;

    // -------------------------------------------------------------------------
    // write channel
    // -------------------------------------------------------------------------
    assign wr_fire = awvalid && awready && wvalid && wready;
    assign amt_ok  = (awaddr == REG_AMOUNT) && !full;  // a full queue drops the command.

    always_comb begin
        case (awaddr)
            REG_OPERAND: wr_resp = RESP_OKAY;
            REG_AMOUNT:  wr_resp = full ? RESP_SLVERR : RESP_OKAY;
            default:     wr_resp = RESP_SLVERR;       // read-only or unmapped.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            push    <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !bvalid && !awready;  // one-cycle pulse.
            wready  <= awvalid && wvalid && !bvalid && !awready;
            push    <= wr_fire && amt_ok;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp     <= wr_resp;
            push_data <= {operand_q, wdata[AMT_W-1:0]};  // pushed on the next edge.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            operand_q <= '0;
            amount_q  <= '0;
        end else if (wr_fire && awaddr == REG_OPERAND) begin
            operand_q <= wdata;
        end else if (wr_fire && amt_ok) begin
            amount_q <= wdata[AMT_W-1:0];
        end
    end

    // -------------------------------------------------------------------------
    // read channel
    // -------------------------------------------------------------------------
    assign rd_fire = arvalid && arready;

    always_comb begin
        rd_resp = RESP_OKAY;
        case (araddr)
            REG_OPERAND:   rd_word = operand_q;
            REG_AMOUNT:    rd_word = DATA_W'(amount_q);
            REG_RES_LEFT:  rd_word = res_left;
            REG_RES_RIGHT: rd_word = res_right;
            REG_STATUS:    rd_word = DATA_W'({idle && !push, done_count});
            default: begin
                rd_word = '0;
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (rd_fire) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (rvalid && rready) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else if (!rvalid) begin
            arready <= 1'b1;  // comes up one cycle after reset.
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

endmodule

// File: design/shift_cmd_fifo.sv
// Shift command queue
`timescale 1ns/1ps

module shift_cmd_fifo (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  logic [shift_pkg::CMD_W-1:0]  push_data,
    output logic                         full,
    input  logic                         pop,
    output logic [shift_pkg::CMD_W-1:0]  pop_data,
    output logic                         empty
);
    import shift_pkg::*;

    logic [CMD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps since the depth is a power of two.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither keeps the level.
            endcase
        end
    end

    assign pop_data = mem[rd_ptr];
    assign full     = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign empty    = (count == '0);

endmodule

// File: design/shift_engine.sv
// Shift engine
`timescale 1ns/1ps

module shift_engine (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic                         pop,
    input  logic [shift_pkg::CMD_W-1:0]  pop_data,
    input  logic                         empty,
    output logic [shift_pkg::DATA_W-1:0] res_left,
    output logic [shift_pkg::DATA_W-1:0] res_right,
    output logic [shift_pkg::CNT_W-1:0]  done_count,
    output logic                         idle
);
    import shift_pkg::*;

    logic [DATA_W-1:0] operand;
    logic [AMT_W-1:0]  amount;
    logic [DATA_W-1:0] onehot;
    logic [DATA_W-1:0] left_d;
    logic [DATA_W-1:0] right_d;

    assign operand = pop_data[CMD_W-1:AMT_W];
    assign amount  = pop_data[AMT_W-1:0];

    always_comb begin
        for (int i = 0; i < DATA_W; i++) begin
            onehot[i] = (amount == AMT_W'(i));
        end
    end

    onehot_shifter_32 u_shifter (
        .shift     (onehot),
        .din       (operand),
        .dleftout  (left_d),
        .drightout (right_d)
    );

    assign pop  = !empty;  // one command per cycle.
    assign idle = empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_left   <= '0;
            res_right  <= '0;
            done_count <= '0;
        end else if (pop) begin
            res_left   <= left_d;
            res_right  <= right_d;
            done_count <= done_count + 1'b1;  // wraps at 256.
        end
    end

endmodule

// File: design/shift_unit_top.sv
// Shift coprocessor top level
`timescale 1ns/1ps

module shift_unit_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [axil_pkg::ADDR_W-1:0]   awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [shift_pkg::DATA_W-1:0]  wdata,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [axil_pkg::RESP_W-1:0]   bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [axil_pkg::ADDR_W-1:0]   araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [shift_pkg::DATA_W-1:0]  rdata,
    output logic [axil_pkg::RESP_W-1:0]   rresp,
    output logic                          rvalid,
    input  logic                          rready
);
    import shift_pkg::*;

    logic              push;
    logic [CMD_W-1:0]  push_data;
    logic              full;
    logic              pop;
    logic [CMD_W-1:0]  pop_data;
    logic              empty;
    logic [DATA_W-1:0] res_left;
    logic [DATA_W-1:0] res_right;
    logic [CNT_W-1:0]  done_count;
    logic              idle;

    shift_cmd_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .push       (push),
        .push_data  (push_data),
        .full       (full),
        .res_left   (res_left),
        .res_right  (res_right),
        .done_count (done_count),
        .idle       (idle)
    );

    shift_cmd_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty)
    );

    shift_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .pop        (pop),
        .pop_data   (pop_data),
        .empty      (empty),
        .res_left   (res_left),
        .res_right  (res_right),
        .done_count (done_count),
        .idle       (idle)
    );

endmodule

// File: testbench/shift_unit_checker.sv
// Shift unit protocol checker
`timescale 1ns/1ps

module shift_unit_checker (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          awready,
    input logic                          wready,
    input logic                          bvalid,
    input logic                          bready,
    input logic                          arready,
    input logic                          rvalid,
    input logic                          rready,
    input logic [shift_pkg::DATA_W-1:0]  rdata,
    input logic                          push,
    input logic                          pop
);
    int error_count = 0;  // failed assertions so far.

    // -------------------------------------------------------------------------
    // reset values
    // -------------------------------------------------------------------------
    assert property (@(posedge clk) !rst_n |=>
        !awready && !wready && !bvalid && !arready && !rvalid && !push && !pop)
        else begin
            error_count++;
            $error("outputs not low after reset");
        end

    // -------------------------------------------------------------------------
    // handshake rules
    // -------------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
        else begin
            error_count++;
            $error("bvalid dropped before bready");
        end

    assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=> rvalid)
        else begin
            error_count++;
            $error("rvalid dropped before rready");
        end

    assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=> $stable(rdata))
        else begin
            error_count++;
            $error("rdata changed while rvalid waited");
        end

    assert property (@(posedge clk) disable iff (!rst_n) $rose(awready) == $rose(wready))
        else begin
            error_count++;
            $error("awready and wready rose apart");
        end

endmodule

bind shift_unit_top shift_unit_checker u_checker (
    .clk (clk), .rst_n (rst_n), .awready (awready), .wready (wready),
    .bvalid (bvalid), .bready (bready), .arready (arready), .rvalid (rvalid),
    .rready (rready), .rdata (rdata), .push (push), .pop (pop)
);

// File: testbench/shift_unit_tb.sv
// Shift unit testbench
`timescale 1ns/1ps

module shift_unit_tb;
    import shift_pkg::*;
    import axil_pkg::*;

    logic              clk;
    logic              rst_n;
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic              wvalid;
    logic              wready;
    logic [RESP_W-1:0] bresp;
    logic              bvalid;
    logic              bready;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    logic [RESP_W-1:0] rresp;
    logic              rvalid;
    logic              rready;

    logic [31:0]       lfsr_state = 32'hf799e7ad;
    logic [CNT_W-1:0]  exp_count  = '0;
    logic [31:0]       patterns [3] = '{32'hffff_ffff, 32'h0000_0001, 32'h8000_0000};
    int                edge_amts [6] = '{0, 7, 8, 15, 24, 31};

    shift_unit_top u_shift_unit_top (.*);

    always #10 clk = ~clk;

    always @(negedge clk) begin
        if (u_shift_unit_top.u_checker.error_count != 0) fail_run("a protocol assertion fired");
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string test, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            fail_run($sformatf("FAIL %s expected 0x%08h actual 0x%08h", test, exp, act));
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1.
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // -------------------------------------------------------------------------
    // host bus tasks start and end just after a falling edge
    // -------------------------------------------------------------------------
    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                              output logic [RESP_W-1:0] resp);
        int          t;
        logic [31:0] stall;
        draw_bits(2, stall);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        for (t = 0; !awready; t++) begin
            if (t > 20) fail_run("write address was never accepted");
            @(negedge clk);
        end
        @(negedge clk);  // transfer happened on the edge just passed.
        awvalid = 1'b0;
        wvalid  = 1'b0;
        for (t = 0; !bvalid; t++) begin
            if (t > 20) fail_run("write response never arrived");
            @(negedge clk);
        end
        repeat (stall) @(negedge clk);
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                             output logic [RESP_W-1:0] resp);
        int          t;
        logic [31:0] stall;
        draw_bits(2, stall);
        araddr  = addr;
        arvalid = 1'b1;
        for (t = 0; !arready; t++) begin
            if (t > 20) fail_run("read address was never accepted");
            @(negedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        for (t = 0; !rvalid; t++) begin
            if (t > 20) fail_run("read data never arrived");
            @(negedge clk);
        end
        repeat (stall) @(negedge clk);
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_count(input logic [CNT_W-1:0] target);
        logic [31:0]       status;
        logic [RESP_W-1:0] resp;
        for (int t = 0; t <= 50; t++) begin
            axil_read(REG_STATUS, status, resp);
            if (status[CNT_W-1:0] == target) return;
        end
        fail_run($sformatf("completion count never reached %0d", target));
    endtask

    task automatic run_shift(input string test, input logic [31:0] operand,
                             input logic [AMT_W-1:0] amt);
        logic [RESP_W-1:0] resp;
        logic [31:0]       data;
        string             name;
        name = $sformatf("%s amount %0d", test, amt);
        axil_write(REG_OPERAND, operand, resp);
        compare_word({name, " operand resp"}, RESP_OKAY, resp);
        axil_write(REG_AMOUNT, amt, resp);
        compare_word({name, " amount resp"}, RESP_OKAY, resp);
        exp_count = exp_count + 1'b1;
        wait_count(exp_count);
        axil_read(REG_RES_LEFT, data, resp);
        compare_word({name, " left"}, operand << amt, data);
        axil_read(REG_RES_RIGHT, data, resp);
        compare_word({name, " right"}, operand >> amt, data);
    endtask

    // -------------------------------------------------------------------------
    // test sequence
    // -------------------------------------------------------------------------
    initial begin
        logic [31:0]       rnd;
        logic [31:0]       data;
        logic [RESP_W-1:0] resp;
        logic [AMT_W-1:0]  last_amt;
        clk = 1'b0;
        rst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        draw_bits(32, rnd);  // register access.
        axil_write(REG_OPERAND, rnd, resp);
        axil_read(REG_OPERAND, data, resp);
        compare_word("operand readback", rnd, data);
        axil_write(REG_RES_LEFT, ~rnd, resp);
        compare_word("read-only write resp", RESP_SLVERR, resp);
        axil_read(REG_RES_LEFT, data, resp);
        compare_word("read-only unchanged", 32'h0, data);  // no command has run yet.
        axil_read(5'h14, data, resp);
        compare_word("unmapped read resp", RESP_SLVERR, resp);
        compare_word("unmapped read data", 32'h0, data);

        for (int a = 0; a < DATA_W; a++) begin
            draw_bits(32, rnd);
            run_shift("random", rnd, AMT_W'(a));
        end
        for (int p = 0; p < 3; p++) begin
            for (int e = 0; e < 6; e++) run_shift("edge", patterns[p], AMT_W'(edge_amts[e]));
        end

        draw_bits(32, rnd);  // back-to-back amount writes.
        axil_write(REG_OPERAND, rnd, resp);
        last_amt = '0;
        for (int i = 0; i < 8; i++) begin
            draw_bits(AMT_W, data);
            axil_write(REG_AMOUNT, data, resp);
            if (resp == RESP_OKAY) begin
                exp_count = exp_count + 1'b1;
                last_amt  = data[AMT_W-1:0];
            end else begin
                compare_word("back-pressure resp", RESP_SLVERR, resp);
            end
        end
        wait_count(exp_count);
        axil_read(REG_RES_LEFT, data, resp);
        compare_word("back-pressure left", rnd << last_amt, data);
        axil_read(REG_RES_RIGHT, data, resp);
        compare_word("back-pressure right", rnd >> last_amt, data);
        axil_read(REG_AMOUNT, data, resp);
        compare_word("last amount", 32'(last_amt), data);
        axil_read(REG_STATUS, data, resp);
        compare_word("idle flag", 32'h1, 32'(data[8]));

        repeat (2) @(negedge clk);
        if (u_shift_unit_top.u_checker.error_count != 0) begin
            fail_run("a protocol assertion fired");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: project.f
design/shift_pkg.sv
design/axil_pkg.sv
design/shift_tile_8.sv
design/onehot_shifter_32.sv
design/shift_cmd_regs.sv
design/shift_cmd_fifo.sv
design/shift_engine.sv
design/shift_unit_top.sv
testbench/shift_unit_checker.sv
testbench/shift_unit_tb.sv
